/* source/lc3b_types.sv */
`default_nettype none

package lc3b_types;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic machine types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;
	typedef logic [2:0]  lc3b_nzp;

	// Standard LC-3b opcode field values.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control word and pipeline stage registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		lc3b_opcode opcode;
		logic       load_regfile;
		logic       load_cc;
		logic [1:0] sr2mux_sel;
		logic       sr2mux2_sel;
		logic       writemux_sel;
		logic       destmux_sel;
		logic       bradd2mux_sel;
		lc3b_aluop  aluop;
		logic       alumux_sel;
		logic       mem_addr_mux_sel;
		logic [1:0] newpcmux_sel;
		// 000 ALU, 001 word load, 010 PC, 011 LEA, 100 byte load.
		logic [2:0] regfilemux_sel;
	} lc3b_control_word;

	typedef struct packed {
		logic             valid;
		lc3b_control_word ctrl;
		lc3b_word         instr;
		lc3b_word         pc;
		lc3b_word         sr1_data;
		lc3b_word         sr2_data;
		lc3b_reg          dest;
	} lc3b_ex_t;

	typedef struct packed {
		logic             valid;
		lc3b_control_word ctrl;
		lc3b_word         alu_out;
		lc3b_word         lea_out;
		lc3b_word         pc;
		lc3b_word         store_data;
		lc3b_reg          dest;
	} lc3b_mem_t;

	typedef struct packed {
		logic     valid;
		lc3b_reg  dest;
		lc3b_word data;
	} lc3b_wb_t;

endpackage : lc3b_types

`default_nettype wire

/* source/control_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module control_rom (
	input  lc3b_types::lc3b_opcode       opcode,
	input  logic                         ir4,
	input  logic                         ir5,
	input  logic                         ir11,
	output lc3b_types::lc3b_control_word ctrl
);

	import lc3b_types::*;

	always_comb begin
		// Pass word with every load off.
		ctrl.opcode           = opcode;
		ctrl.load_regfile     = 1'b0;
		ctrl.load_cc          = 1'b0;
		ctrl.sr2mux_sel       = 2'b00;
		ctrl.sr2mux2_sel      = 1'b0;
		ctrl.writemux_sel     = 1'b0;
		ctrl.destmux_sel      = 1'b0;
		ctrl.bradd2mux_sel    = 1'b0;
		ctrl.aluop            = alu_pass;
		ctrl.alumux_sel       = 1'b0;
		ctrl.mem_addr_mux_sel = 1'b0;
		ctrl.newpcmux_sel     = 2'b00;
		ctrl.regfilemux_sel   = 3'b000;

		case (opcode)
			op_add, op_and: begin
				// Bit 5 picks the imm5 form.
				if (ir5) begin
					ctrl.sr2mux_sel  = 2'b10;
					ctrl.sr2mux2_sel = 1'b1;
				end
				ctrl.aluop        = (opcode == op_add) ? alu_add : alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
			end

			op_not: begin
				ctrl.aluop        = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
			end

			op_shf: begin
				// Bit 4 is direction, bit 5 arithmetic on right shifts.
				ctrl.sr2mux_sel  = 2'b11;
				ctrl.sr2mux2_sel = 1'b1;
				if (!ir4)
					ctrl.aluop = alu_sll;
				else if (!ir5)
					ctrl.aluop = alu_srl;
				else
					ctrl.aluop = alu_sra;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc      = 1'b1;
			end

			op_ldr: begin
				// Base plus scaled offset6.
				ctrl.sr2mux2_sel    = 1'b1;
				ctrl.aluop          = alu_add;
				ctrl.regfilemux_sel = 3'b001;
				ctrl.load_regfile   = 1'b1;
				ctrl.load_cc        = 1'b1;
			end

			op_ldb: begin
				// Base plus unscaled offset6.
				ctrl.sr2mux_sel     = 2'b01;
				ctrl.sr2mux2_sel    = 1'b1;
				ctrl.aluop          = alu_add;
				ctrl.regfilemux_sel = 3'b100;
				ctrl.load_regfile   = 1'b1;
				ctrl.load_cc        = 1'b1;
			end

			op_str: begin
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop       = alu_add;
			end

			op_stb: begin
				ctrl.sr2mux_sel  = 2'b01;
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop       = alu_add;
			end

			op_lea: begin
				ctrl.regfilemux_sel = 3'b011;
				ctrl.load_regfile   = 1'b1;
				ctrl.load_cc        = 1'b1;
			end

			op_br: begin
				ctrl.newpcmux_sel = 2'b01;
			end

			op_jmp: begin
				ctrl.bradd2mux_sel = 1'b1;
			end

			op_jsr: begin
				// Link into R7. JSRR takes its target from BaseR.
				ctrl.writemux_sel   = 1'b1;
				ctrl.regfilemux_sel = 3'b010;
				ctrl.load_regfile   = 1'b1;
				if (!ir11)
					ctrl.bradd2mux_sel = 1'b1;
			end

			op_trap: begin
				ctrl.writemux_sel   = 1'b1;
				ctrl.regfilemux_sel = 3'b010;
				ctrl.load_regfile   = 1'b1;
				ctrl.alumux_sel     = 1'b1;
				ctrl.newpcmux_sel   = 2'b10;
			end

			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule : control_rom

`default_nettype wire

/* source/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  lc3b_types::lc3b_reg  sr1,
	input  lc3b_types::lc3b_reg  sr2,
	input  lc3b_types::lc3b_reg  dest,
	input  lc3b_types::lc3b_word in,
	output lc3b_types::lc3b_word sr1_out,
	output lc3b_types::lc3b_word sr2_out
);

	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// Write-through so a same-cycle read sees the new value.
	assign sr1_out = (load && (dest == sr1)) ? in : regs[sr1];
	assign sr2_out = (load && (dest == sr2)) ? in : regs[sr2];

endmodule : regfile

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  lc3b_types::lc3b_aluop aluop,
	input  lc3b_types::lc3b_word  a,
	input  lc3b_types::lc3b_word  b,
	output lc3b_types::lc3b_word  f
);

	import lc3b_types::*;

	logic [3:0] shamt;

	// Shift distance is the imm4 field.
	assign shamt = b[3:0];

	always_comb begin
		case (aluop)
			alu_add:  f = a + b;
			alu_and:  f = a & b;
			alu_not:  f = ~a;
			alu_pass: f = a;
			alu_sll:  f = a << shamt;
			alu_srl:  f = a >> shamt;
			// Sign bit fills from the left.
			alu_sra:  f = lc3b_word'($signed(a) >>> shamt);
			default:  f = '0;
		endcase
	end

endmodule : alu

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  lc3b_types::lc3b_ex_t  ex_in,
	output lc3b_types::lc3b_word  fwd_data,
	output lc3b_types::lc3b_mem_t mem_out
);

	import lc3b_types::*;

	lc3b_word offset6_sext;
	lc3b_word offset6_word;
	lc3b_word imm5_sext;
	lc3b_word imm4_zext;
	lc3b_word pcoffset9;
	lc3b_word imm_op;
	lc3b_word sr2_op;
	lc3b_word alu_out;
	lc3b_word lea_out;
	lc3b_mem_t mem_d;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Immediate fields.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign offset6_sext = {{10{ex_in.instr[5]}}, ex_in.instr[5:0]};
	assign offset6_word = {{9{ex_in.instr[5]}}, ex_in.instr[5:0], 1'b0};
	assign imm5_sext    = {{11{ex_in.instr[4]}}, ex_in.instr[4:0]};
	assign imm4_zext    = {12'h000, ex_in.instr[3:0]};
	assign pcoffset9    = {{6{ex_in.instr[8]}}, ex_in.instr[8:0], 1'b0};

	always_comb begin
		case (ex_in.ctrl.sr2mux_sel)
			2'b00:   imm_op = offset6_word;
			2'b01:   imm_op = offset6_sext;
			2'b10:   imm_op = imm5_sext;
			default: imm_op = imm4_zext;
		endcase
	end

	assign sr2_op = ex_in.ctrl.sr2mux2_sel ? imm_op : ex_in.sr2_data;

	alu u_alu (
		.aluop (ex_in.ctrl.aluop),
		.a     (ex_in.sr1_data),
		.b     (sr2_op),
		.f     (alu_out)
	);

	assign lea_out = ex_in.pc + pcoffset9;

	// Value this instruction will write, for the decode bypass.
	always_comb begin
		case (ex_in.ctrl.regfilemux_sel)
			3'b010:  fwd_data = ex_in.pc;
			3'b011:  fwd_data = lea_out;
			default: fwd_data = alu_out;
		endcase
	end

	always_comb begin
		mem_d.valid      = ex_in.valid;
		mem_d.ctrl       = ex_in.ctrl;
		mem_d.alu_out    = alu_out;
		mem_d.lea_out    = lea_out;
		mem_d.pc         = ex_in.pc;
		mem_d.store_data = ex_in.sr2_data;
		mem_d.dest       = ex_in.dest;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_out.valid <= 1'b0;
		else
			mem_out <= mem_d;
	end

	// Word accesses from a forwarded base stay aligned.
	a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_in.valid && (ex_in.ctrl.opcode inside {op_ldr, op_str})) |-> !alu_out[0])
		else $error("unaligned word access at %h", alu_out);

endmodule : execute_stage

`default_nettype wire

/* source/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_stage #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lc3b_types::lc3b_mem_t mem_in,
	output lc3b_types::lc3b_wb_t  wb_comb,
	output lc3b_types::lc3b_wb_t  wb,
	output lc3b_types::lc3b_nzp   cc
);

	import lc3b_types::*;

	localparam int AW = $clog2(DMEM_WORDS);

	lc3b_word dmem [DMEM_WORDS];

	logic [AW-1:0] addr;
	lc3b_word      rdata;
	logic [7:0]    rbyte;
	logic          store_word;
	logic          store_byte;
	lc3b_word      result;
	lc3b_nzp       nzp;

	// Word index sits above the byte select bit.
	assign addr  = mem_in.alu_out[AW:1];
	assign rdata = dmem[addr];
	assign rbyte = mem_in.alu_out[0] ? rdata[15:8] : rdata[7:0];

	assign store_word = mem_in.valid && (mem_in.ctrl.opcode == op_str);
	assign store_byte = mem_in.valid && (mem_in.ctrl.opcode == op_stb);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data memory.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (store_word) begin
			dmem[addr] <= mem_in.store_data;
		end else if (store_byte) begin
			// One byte lane, chosen by address bit 0.
			if (mem_in.alu_out[0])
				dmem[addr][15:8] <= mem_in.store_data[7:0];
			else
				dmem[addr][7:0] <= mem_in.store_data[7:0];
		end
	end

	always_comb begin
		case (mem_in.ctrl.regfilemux_sel)
			3'b001:  result = rdata;
			3'b010:  result = mem_in.pc;
			3'b011:  result = mem_in.lea_out;
			3'b100:  result = {8'h00, rbyte};
			default: result = mem_in.alu_out;
		endcase
	end

	// Link writes always target R7.
	assign wb_comb.valid = mem_in.valid && mem_in.ctrl.load_regfile;
	assign wb_comb.dest  = mem_in.ctrl.writemux_sel ? 3'd7 : mem_in.dest;
	assign wb_comb.data  = result;

	always_comb begin
		if (result[15])
			nzp = 3'b100;
		else if (result == '0)
			nzp = 3'b010;
		else
			nzp = 3'b001;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
			cc <= 3'b010;
		end else begin
			wb <= wb_comb;
			if (mem_in.valid && mem_in.ctrl.load_cc)
				cc <= nzp;
		end
	end

endmodule : memory_stage

`default_nettype wire

/* source/lc3b_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_datapath #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  lc3b_types::lc3b_word instr,
	input  lc3b_types::lc3b_word instr_pc,
	output lc3b_types::lc3b_wb_t wb,
	output lc3b_types::lc3b_nzp  cc
);

	import lc3b_types::*;

	lc3b_opcode       dec_opcode;
	lc3b_control_word dec_ctrl;
	lc3b_reg          sr1_idx;
	lc3b_reg          sr2_idx;
	logic             is_store;
	lc3b_word         sr1_rf;
	lc3b_word         sr2_rf;
	lc3b_word         sr1_fwd;
	lc3b_word         sr2_fwd;
	lc3b_ex_t         ex_d;
	lc3b_ex_t         ex_q;
	lc3b_word         ex_fwd_data;
	lc3b_reg          ex_dest;
	logic             ex_is_load;
	logic             ex_fwd_ok;
	lc3b_mem_t        mem_q;
	lc3b_wb_t         wb_comb;
	logic             uses_sr1;
	logic             uses_sr2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign dec_opcode = lc3b_opcode'(instr[15:12]);

	control_rom u_control_rom (
		.opcode (dec_opcode),
		.ir4    (instr[4]),
		.ir5    (instr[5]),
		.ir11   (instr[11]),
		.ctrl   (dec_ctrl)
	);

	// Stores read their SR field on the second port.
	assign is_store = dec_opcode inside {op_str, op_stb};
	assign sr1_idx  = instr[8:6];
	assign sr2_idx  = is_store ? instr[11:9] : instr[2:0];

	// Write-through here carries the memory stage result.
	regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (wb_comb.valid),
		.sr1     (sr1_idx),
		.sr2     (sr2_idx),
		.dest    (wb_comb.dest),
		.in      (wb_comb.data),
		.sr1_out (sr1_rf),
		.sr2_out (sr2_rf)
	);

	// Execute result is not yet known for a load.
	assign ex_dest    = ex_q.ctrl.writemux_sel ? 3'd7 : ex_q.dest;
	assign ex_is_load = ex_q.ctrl.regfilemux_sel inside {3'b001, 3'b100};
	assign ex_fwd_ok  = ex_q.valid && ex_q.ctrl.load_regfile && !ex_is_load;

	assign sr1_fwd = (ex_fwd_ok && (ex_dest == sr1_idx)) ? ex_fwd_data : sr1_rf;
	assign sr2_fwd = (ex_fwd_ok && (ex_dest == sr2_idx)) ? ex_fwd_data : sr2_rf;

	always_comb begin
		ex_d.valid    = instr_valid;
		ex_d.ctrl     = dec_ctrl;
		ex_d.instr    = instr;
		ex_d.pc       = instr_pc;
		ex_d.sr1_data = sr1_fwd;
		ex_d.sr2_data = sr2_fwd;
		ex_d.dest     = instr[11:9];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_q.valid <= 1'b0;
		else
			ex_q <= ex_d;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute and memory stages.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	execute_stage u_execute_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_in    (ex_q),
		.fwd_data (ex_fwd_data),
		.mem_out  (mem_q)
	);

	memory_stage #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_memory_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.mem_in  (mem_q),
		.wb_comb (wb_comb),
		.wb      (wb),
		.cc      (cc)
	);

	// Source registers actually read by the decoding instruction.
	assign uses_sr1 = dec_opcode inside {op_add, op_and, op_not, op_shf,
	                                     op_ldr, op_ldb, op_str, op_stb};
	assign uses_sr2 = is_store || ((dec_opcode inside {op_add, op_and}) && !instr[5]);

	// No source may depend on a load one slot ahead.
	a_load_use: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_valid && ex_q.valid && ex_is_load && ex_q.ctrl.load_regfile) |->
		!((uses_sr1 && (ex_dest == sr1_idx)) || (uses_sr2 && (ex_dest == sr2_idx))))
		else $error("load-use hazard on R%0d", ex_dest);

endmodule : lc3b_datapath

`default_nettype wire

/* verification/lc3b_test_table.svh */
// Columns: valid, instr, pc, wb valid, wb dest, wb data, check cc, cc.
// All registers and memory start at zero.

// ALU operations with forwarding at distances one, two and three.
add_row(1'b1, 16'h1225, 16'h3002, 1'b1, 3'd1, 16'h0005, 1'b1, 3'b001); // ADD R1,R0,#5
add_row(1'b1, 16'h147D, 16'h3004, 1'b1, 3'd2, 16'h0002, 1'b1, 3'b001); // ADD R2,R1,#-3
add_row(1'b1, 16'h1642, 16'h3006, 1'b1, 3'd3, 16'h0007, 1'b1, 3'b001); // ADD R3,R1,R2
add_row(1'b1, 16'h5842, 16'h3008, 1'b1, 3'd4, 16'h0000, 1'b1, 3'b010); // AND R4,R1,R2
add_row(1'b1, 16'h5AE6, 16'h300A, 1'b1, 3'd5, 16'h0006, 1'b1, 3'b001); // AND R5,R3,#6
add_row(1'b1, 16'h9D7F, 16'h300C, 1'b1, 3'd6, 16'hFFF9, 1'b1, 3'b100); // NOT R6,R5

// Shifts.
add_row(1'b1, 16'hD843, 16'h300E, 1'b1, 3'd4, 16'h0028, 1'b1, 3'b001); // LSHF R4,R1,#3
add_row(1'b1, 16'hD594, 16'h3010, 1'b1, 3'd2, 16'h0FFF, 1'b1, 3'b001); // RSHFL R2,R6,#4
add_row(1'b1, 16'hD7B2, 16'h3012, 1'b1, 3'd3, 16'hFFFE, 1'b1, 3'b100); // RSHFA R3,R6,#2

// Stores then loads, word and byte.
add_row(1'b1, 16'h7B01, 16'h3014, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b100); // STR R5,R4,#1
add_row(1'b1, 16'h3D05, 16'h3016, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b100); // STB R6,R4,#5
add_row(1'b1, 16'h6301, 16'h3018, 1'b1, 3'd1, 16'h0006, 1'b1, 3'b001); // LDR R1,R4,#1
add_row(1'b1, 16'h2505, 16'h301A, 1'b1, 3'd2, 16'h00F9, 1'b1, 3'b001); // LDB R2,R4,#5

// Bubble keeps the load-use gap.
add_row(1'b0, 16'h0000, 16'h0000, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b001);
add_row(1'b1, 16'h1A42, 16'h301E, 1'b1, 3'd5, 16'h00FF, 1'b1, 3'b001); // ADD R5,R1,R2

// PC based results.
add_row(1'b1, 16'hE610, 16'h3020, 1'b1, 3'd3, 16'h3040, 1'b1, 3'b001); // LEA R3,#16
add_row(1'b1, 16'h1CE1, 16'h3022, 1'b1, 3'd6, 16'h3041, 1'b1, 3'b001); // ADD R6,R3,#1
add_row(1'b1, 16'h5020, 16'h3024, 1'b1, 3'd0, 16'h0000, 1'b1, 3'b010); // AND R0,R0,#0
add_row(1'b1, 16'h4804, 16'h3026, 1'b1, 3'd7, 16'h3026, 1'b1, 3'b010); // JSR
add_row(1'b1, 16'h93FF, 16'h3028, 1'b1, 3'd1, 16'hCFD9, 1'b1, 3'b100); // NOT R1,R7
add_row(1'b1, 16'hF025, 16'h302A, 1'b1, 3'd7, 16'h302A, 1'b1, 3'b100); // TRAP x25
add_row(1'b1, 16'h0E02, 16'h302C, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b001); // BRnzp
add_row(1'b1, 16'hC1C0, 16'h302E, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b001); // JMP R7
add_row(1'b1, 16'h95FF, 16'h3030, 1'b1, 3'd2, 16'hCFD5, 1'b1, 3'b100); // NOT R2,R7
add_row(1'b1, 16'h1886, 16'h3032, 1'b1, 3'd4, 16'h0016, 1'b1, 3'b001); // ADD R4,R2,R6

// Store data taken from the execute bypass.
add_row(1'b1, 16'h7803, 16'h3034, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b001); // STR R4,R0,#3
add_row(1'b1, 16'h6A03, 16'h3036, 1'b1, 3'd5, 16'h0016, 1'b1, 3'b001); // LDR R5,R0,#3

/* verification/tb_lc3b_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_datapath;

	import lc3b_types::*;

	typedef struct packed {
		logic     valid;
		lc3b_word instr;
		lc3b_word pc;
		lc3b_wb_t exp_wb;
		logic     chk_cc;
		lc3b_nzp  exp_cc;
	} test_row_t;

	logic     clk;
	logic     rst_n;
	logic     instr_valid;
	lc3b_word instr;
	lc3b_word instr_pc;
	lc3b_wb_t wb;
	lc3b_nzp  cc;

	test_row_t rows [$];
	lc3b_wb_t  idle_wb;
	int        wb_errors;
	int        cc_errors;
	int        cycles;
	int        cycle_limit;

	lc3b_datapath #(
		.DMEM_WORDS (256)
	) u_lc3b_datapath (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.wb          (wb),
		.cc          (cc)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table building and result checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic add_row(input logic v, input lc3b_word ir, input lc3b_word pc,
			input logic wv, input lc3b_reg wd, input lc3b_word wdata,
			input logic chk, input lc3b_nzp nzp);
		test_row_t r;
		r.valid        = v;
		r.instr        = ir;
		r.pc           = pc;
		r.exp_wb.valid = wv;
		r.exp_wb.dest  = wd;
		r.exp_wb.data  = wdata;
		r.chk_cc       = chk;
		r.exp_cc       = nzp;
		rows.push_back(r);
	endtask

	task automatic build_table();
		`include "lc3b_test_table.svh"
	endtask

	// Dest and data only matter when a register write is expected.
	task automatic check_wb(input lc3b_wb_t got, input lc3b_wb_t exp, input string what);
		if (got.valid !== exp.valid ||
				(exp.valid && (got.dest !== exp.dest || got.data !== exp.data))) begin
			wb_errors++;
			$display("Error at %0t ns: %s wb got v=%b R%0d=%h, expected v=%b R%0d=%h",
				$time, what, got.valid, got.dest, got.data,
				exp.valid, exp.dest, exp.data);
		end
	endtask

	task automatic check_cc(input lc3b_nzp got, input lc3b_nzp exp, input string what);
		if (got !== exp) begin
			cc_errors++;
			$display("Error at %0t ns: %s cc got %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and checking.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		instr_pc    = '0;
		idle_wb     = '0;
		wb_errors   = 0;
		cc_errors   = 0;
		build_table();
		cycle_limit = rows.size() + 20;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Row c is sampled one edge after it is driven, so its result shows at c+3.
		for (int c = 0; c < rows.size() + 3; c++) begin
			@(posedge clk);
			if (c < rows.size()) begin
				instr_valid <= rows[c].valid;
				instr       <= rows[c].instr;
				instr_pc    <= rows[c].pc;
			end else begin
				instr_valid <= 1'b0;
				instr       <= '0;
				instr_pc    <= '0;
			end
			@(negedge clk);
			if (c >= 3) begin
				check_wb(wb, rows[c-3].exp_wb, $sformatf("row %0d", c - 3));
				if (rows[c-3].chk_cc)
					check_cc(cc, rows[c-3].exp_cc, $sformatf("row %0d", c - 3));
			end else begin
				check_wb(wb, idle_wb, "after reset");
				check_cc(cc, 3'b010, "after reset");
			end
		end

		$display("Closing: %0d wb errors, %0d cc errors", wb_errors, cc_errors);
		if (wb_errors == 0 && cc_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (cycle_limit == 0 || cycles <= cycle_limit);
		$display("Timeout: the run went past %0d clock cycles", cycle_limit);
		$display("TB FAILED");
		$finish;
	end

endmodule : tb_lc3b_datapath

`default_nettype wire

/* tb.f */
+incdir+verification
source/lc3b_types.sv
source/control_rom.sv
source/regfile.sv
source/alu.sv
source/execute_stage.sv
source/memory_stage.sv
source/lc3b_datapath.sv
verification/tb_lc3b_datapath.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lc3b_datapath
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line.
run: compile
	@out="$$(./$(SIM))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)
